// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen = 32;  // data and address width

    // major opcode, inst[6:0]
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,  // beq/bne/blt/bge/bltu/bgeu
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_other  = 7'b0010011   // any non-control opcode, op-imm as example
    } opcode_e;

    // what the predictor cares about
    typedef enum logic [1:0] {
        cls_none,
        cls_branch,
        cls_jal,
        cls_jalr
    } inst_class_e;

    // link registers used by the return hint
    localparam logic [4:0] reg_ra = 5'd1;  // x1
    localparam logic [4:0] reg_t0 = 5'd5;  // x5, alternate link

endpackage

// ==== src/bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    // bimodal direction table
    localparam int bim_entries = 64;
    localparam int bim_idx_w   = 6;   // pc[6:1]

    // branch target buffer, direct mapped
    localparam int btb_entries = 16;
    localparam int btb_idx_w   = 4;   // pc[5:2]
    localparam int btb_tag_w   = 26;  // pc[31:6]

    // return address stack
    localparam int ras_depth = 8;
    localparam int ras_ptr_w = 4;     // pointer runs 0..8, 8 means full

    // 2-bit saturating counter encodings
    // 00 strong not taken, 01 weak not taken, 10 weak taken, 11 strong taken
    localparam logic [1:0] ctr_reset = 2'b01;
    localparam logic [1:0] ctr_max   = 2'b11;

endpackage

// ==== src/inst_classifier.sv ====
`timescale 1ns/1ns

module inst_classifier (
    input  logic [31:0]                   inst_i,
    output rv_isa_pkg::inst_class_e       class_o,
    output logic                          is_ret_o,
    output logic [31:0]                   b_offset_o,
    output logic [31:0]                   j_offset_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [11:0]         i_imm;
    logic                rs1_is_link;

    assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign i_imm  = inst_i[31:20];

    always_comb begin
        case (opcode)
            rv_isa_pkg::op_branch: class_o = rv_isa_pkg::cls_branch;
            rv_isa_pkg::op_jal:    class_o = rv_isa_pkg::cls_jal;
            rv_isa_pkg::op_jalr:   class_o = rv_isa_pkg::cls_jalr;
            default:               class_o = rv_isa_pkg::cls_none;
        endcase
    end

    assign rs1_is_link = (rs1 == rv_isa_pkg::reg_ra) || (rs1 == rv_isa_pkg::reg_t0);

    // ret: jalr x0, 0(ra|t0)
    assign is_ret_o = (opcode == rv_isa_pkg::op_jalr) && (rd == 5'd0)
                      && rs1_is_link && (i_imm == 12'd0);

    // B-type immediate, sign extended
    assign b_offset_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};

    // J-type immediate
    assign j_offset_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

endmodule

// ==== src/bimodal_table.sv ====
`timescale 1ns/1ns

module bimodal_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_isa_pkg::xlen-1:0]   rd_pc_i,
    input  logic                          upd_valid_i,
    input  logic [rv_isa_pkg::xlen-1:0]   upd_pc_i,
    input  logic                          upd_taken_i,
    output logic                          taken_o
);

    logic [1:0]                      ctr_q [bpu_cfg_pkg::bim_entries];
    logic [bpu_cfg_pkg::bim_idx_w-1:0] rd_idx;
    logic [bpu_cfg_pkg::bim_idx_w-1:0] upd_idx;
    logic [1:0]                      upd_ctr;

    // halfword granular index, pc[6:1]
    assign rd_idx  = rd_pc_i[bpu_cfg_pkg::bim_idx_w:1];
    assign upd_idx = upd_pc_i[bpu_cfg_pkg::bim_idx_w:1];
    assign upd_ctr = ctr_q[upd_idx];

    assign taken_o = ctr_q[rd_idx][1];  // msb gives direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_cfg_pkg::bim_entries; i++) begin
                ctr_q[i] <= bpu_cfg_pkg::ctr_reset;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                if (upd_ctr != bpu_cfg_pkg::ctr_max) begin
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'b00) begin  // saturate at strong not taken
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// ==== src/branch_target_buffer.sv ====
`timescale 1ns/1ns

module branch_target_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_isa_pkg::xlen-1:0]   rd_pc_i,
    input  logic                          wr_valid_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wr_pc_i,
    input  logic [rv_isa_pkg::xlen-1:0]   wr_target_i,
    output logic                          hit_o,
    output logic [rv_isa_pkg::xlen-1:0]   target_o
);

    localparam int idx_w = bpu_cfg_pkg::btb_idx_w;
    localparam int tag_w = bpu_cfg_pkg::btb_tag_w;
    localparam int aw    = rv_isa_pkg::xlen;

    logic [bpu_cfg_pkg::btb_entries-1:0] valid_q;
    logic [tag_w-1:0]                    tag_q    [bpu_cfg_pkg::btb_entries];
    logic [aw-1:0]                       target_q [bpu_cfg_pkg::btb_entries];

    logic [idx_w-1:0] rd_idx;
    logic [tag_w-1:0] rd_tag;
    logic [idx_w-1:0] wr_idx;
    logic [tag_w-1:0] wr_tag;

    // word index pc[5:2], tag is everything above
    assign rd_idx = rd_pc_i[idx_w+1:2];
    assign rd_tag = rd_pc_i[aw-1:aw-tag_w];
    assign wr_idx = wr_pc_i[idx_w+1:2];
    assign wr_tag = wr_pc_i[aw-1:aw-tag_w];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target only matter once valid is set
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// ==== src/return_stack.sv ====
`timescale 1ns/1ns

module return_stack (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push_i,
    input  logic [rv_isa_pkg::xlen-1:0]   push_data_i,
    input  logic                          ex_valid_i,
    input  logic                          ex_taken_i,
    input  logic                          ex_is_ret_i,
    input  logic                          ex_stall_i,
    input  logic                          id_stall_i,
    output logic                          empty_o,
    output logic [rv_isa_pkg::xlen-1:0]   top_o
);

    localparam int pw = bpu_cfg_pkg::ras_ptr_w;

    logic [rv_isa_pkg::xlen-1:0] stack_q [bpu_cfg_pkg::ras_depth];
    logic [pw-1:0]               sp_q;       // next free slot
    logic [pw-1:0]               sp_m1;
    logic [pw-1:0]               sp_pop;     // pointer after a possible pop
    logic                        do_pop;
    logic                        do_push;

    assign empty_o = (sp_q == '0);
    assign sp_m1   = sp_q - 1'b1;
    assign top_o   = stack_q[sp_m1[pw-2:0]];  // entry below the pointer

    // a taken return retiring in ex
    assign do_pop = ex_valid_i && ex_taken_i && ex_is_ret_i
                    && !ex_stall_i && !empty_o;

    assign sp_pop = do_pop ? sp_m1 : sp_q;

    // full test after the pop, so pop+push in one cycle replaces the top
    assign do_push = push_i && !ex_stall_i && !id_stall_i
                     && (sp_pop != pw'(bpu_cfg_pkg::ras_depth));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_push) begin
            sp_q <= sp_pop + 1'b1;
        end else begin
            sp_q <= sp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_pop[pw-2:0]] <= push_data_i;  // slot freed by the pop, if any
        end
    end

endmodule

// ==== src/next_pc_select.sv ====
`timescale 1ns/1ns

module next_pc_select (
    input  logic [rv_isa_pkg::xlen-1:0]   pc_i,
    input  rv_isa_pkg::inst_class_e       class_i,
    input  logic                          is_ret_i,
    input  logic [31:0]                   b_offset_i,
    input  logic [31:0]                   j_offset_i,
    input  logic                          bim_taken_i,
    input  logic                          btb_hit_i,
    input  logic [rv_isa_pkg::xlen-1:0]   btb_target_i,
    input  logic                          ras_empty_i,
    input  logic [rv_isa_pkg::xlen-1:0]   ras_top_i,
    input  logic                          push_valid_i,
    input  logic [rv_isa_pkg::xlen-1:0]   push_data_i,
    output logic                          branch_or_not_o,
    output logic                          pdt_res_o,
    output logic [rv_isa_pkg::xlen-1:0]   pdt_pc_o
);

    logic [rv_isa_pkg::xlen-1:0] pc_plus4;
    logic [rv_isa_pkg::xlen-1:0] b_target;
    logic [rv_isa_pkg::xlen-1:0] j_target;

    assign pc_plus4 = pc_i + 32'd4;
    assign b_target = pc_i + b_offset_i;
    assign j_target = pc_i + j_offset_i;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;  // fall through by default

        case (class_i)
            rv_isa_pkg::cls_jalr: begin
                branch_or_not_o = 1'b1;
                if (is_ret_i) begin
                    // call seen in decode this cycle wins over the stack
                    if (push_valid_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = push_data_i;
                    end else if (!ras_empty_i) begin
                        pdt_res_o = 1'b1;
                        pdt_pc_o  = ras_top_i;
                    end
                end
                // indirect jumps other than returns stay not taken
            end
            rv_isa_pkg::cls_jal: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = 1'b1;
                pdt_pc_o        = btb_hit_i ? btb_target_i : j_target;
            end
            rv_isa_pkg::cls_branch: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = bim_taken_i;
                if (bim_taken_i) begin
                    pdt_pc_o = btb_hit_i ? btb_target_i : b_target;
                end
            end
            default: ;  // cls_none, keep defaults
        endcase
    end

endmodule

// ==== src/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top (
    input  logic                          clk,
    input  logic                          rst,
    // fetch
    input  logic [rv_isa_pkg::xlen-1:0]   if_pc_i,
    input  logic [31:0]                   if_inst_i,
    // execute feedback
    input  logic                          ex_branch_valid_i,
    input  logic                          ex_branch_taken_i,
    input  logic [rv_isa_pkg::xlen-1:0]   ex_pc_i,
    input  logic [rv_isa_pkg::xlen-1:0]   ex_target_i,
    input  logic [31:0]                   ex_inst_i,
    // call from decode
    input  logic                          id_ras_push_valid_i,
    input  logic [rv_isa_pkg::xlen-1:0]   id_ras_push_data_i,
    input  logic                          ex_stall_valid_i,
    input  logic                          id_stall_i,
    // prediction
    output logic                          branch_or_not_o,
    output logic                          pdt_res_o,
    output logic [rv_isa_pkg::xlen-1:0]   pdt_pc_o
);

    rv_isa_pkg::inst_class_e     if_class;
    logic                        if_is_ret;
    logic [31:0]                 if_b_offset;
    logic [31:0]                 if_j_offset;
    logic                        ex_is_ret;
    logic                        bim_taken;
    logic                        btb_wr_valid;
    logic                        btb_hit;
    logic [rv_isa_pkg::xlen-1:0] btb_target;
    logic                        ras_empty;
    logic [rv_isa_pkg::xlen-1:0] ras_top;

    assign btb_wr_valid = ex_branch_valid_i & ex_branch_taken_i;  // only taken targets

    inst_classifier i_if_classifier (
        .inst_i     (if_inst_i),
        .class_o    (if_class),
        .is_ret_o   (if_is_ret),
        .b_offset_o (if_b_offset),
        .j_offset_o (if_j_offset)
    );

    // only the return flag is needed at execute
    inst_classifier i_ex_classifier (
        .inst_i     (ex_inst_i),
        .class_o    (),
        .is_ret_o   (ex_is_ret),
        .b_offset_o (),
        .j_offset_o ()
    );

    bimodal_table i_bimodal_table (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .upd_valid_i (ex_branch_valid_i),
        .upd_pc_i    (ex_pc_i),
        .upd_taken_i (ex_branch_taken_i),
        .taken_o     (bim_taken)
    );

    branch_target_buffer i_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .wr_valid_i  (btb_wr_valid),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    return_stack i_return_stack (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_ras_push_valid_i),
        .push_data_i (id_ras_push_data_i),
        .ex_valid_i  (ex_branch_valid_i),
        .ex_taken_i  (ex_branch_taken_i),
        .ex_is_ret_i (ex_is_ret),
        .ex_stall_i  (ex_stall_valid_i),
        .id_stall_i  (id_stall_i),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    next_pc_select i_next_pc_select (
        .pc_i            (if_pc_i),
        .class_i         (if_class),
        .is_ret_i        (if_is_ret),
        .b_offset_i      (if_b_offset),
        .j_offset_i      (if_j_offset),
        .bim_taken_i     (bim_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ras_empty_i     (ras_empty),
        .ras_top_i       (ras_top),
        .push_valid_i    (id_ras_push_valid_i),
        .push_data_i     (id_ras_push_data_i),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

endmodule

// ==== dv/bpu_ref_model.svh ====
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// mirror of the predictor state, updated once per rising edge
logic [1:0]  ctr_mirror        [bpu_cfg_pkg::bim_entries];
logic        btb_valid_mirror  [bpu_cfg_pkg::btb_entries];
logic [31:0] btb_pc_mirror     [bpu_cfg_pkg::btb_entries];  // whole pc, tag taken from it
logic [31:0] btb_target_mirror [bpu_cfg_pkg::btb_entries];
logic [31:0] ras_mirror        [bpu_cfg_pkg::ras_depth];
int          ras_count;

function automatic void reset_model();
    for (int i = 0; i < bpu_cfg_pkg::bim_entries; i++) begin
        ctr_mirror[i] = bpu_cfg_pkg::ctr_reset;
    end
    for (int i = 0; i < bpu_cfg_pkg::btb_entries; i++) begin
        btb_valid_mirror[i]  = 1'b0;
        btb_pc_mirror[i]     = '0;
        btb_target_mirror[i] = '0;
    end
    ras_count = 0;
endfunction

function automatic int counter_slot(input logic [31:0] pc);
    return int'((pc >> 1) % bpu_cfg_pkg::bim_entries);  // halfword granular
endfunction

function automatic int btb_slot(input logic [31:0] pc);
    return int'((pc >> 2) % bpu_cfg_pkg::btb_entries);
endfunction

// jalr x0, 0(ra) or jalr x0, 0(t0)
function automatic logic is_return(input logic [31:0] inst);
    return (inst[6:0] == rv_isa_pkg::op_jalr) && (inst[11:7] == 5'd0)
           && (inst[31:20] == 12'd0)
           && ((inst[19:15] == rv_isa_pkg::reg_ra) || (inst[19:15] == rv_isa_pkg::reg_t0));
endfunction

function automatic void predict(input logic [31:0] pc, input logic [31:0] inst,
                                input logic push_v, input logic [31:0] push_d,
                                output logic br, output logic taken,
                                output logic [31:0] next_pc);
    logic [31:0] b_off;
    logic [31:0] j_off;
    logic        hit;
    int          slot;
    slot    = btb_slot(pc);
    hit     = btb_valid_mirror[slot] && ((btb_pc_mirror[slot] >> (bpu_cfg_pkg::btb_idx_w + 2))
              == (pc >> (bpu_cfg_pkg::btb_idx_w + 2)));
    b_off   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    j_off   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    br      = 1'b0;
    taken   = 1'b0;
    next_pc = pc + 32'd4;
    if (inst[6:0] == rv_isa_pkg::op_jalr) begin
        br = 1'b1;
        if (is_return(inst) && push_v) begin
            taken   = 1'b1;
            next_pc = push_d;  // call in decode this cycle
        end else if (is_return(inst) && ras_count > 0) begin
            taken   = 1'b1;
            next_pc = ras_mirror[ras_count - 1];
        end
    end else if (inst[6:0] == rv_isa_pkg::op_jal) begin
        br      = 1'b1;
        taken   = 1'b1;
        next_pc = hit ? btb_target_mirror[slot] : pc + j_off;
    end else if (inst[6:0] == rv_isa_pkg::op_branch) begin
        br    = 1'b1;
        taken = ctr_mirror[counter_slot(pc)][1];
        if (taken) begin
            next_pc = hit ? btb_target_mirror[slot] : pc + b_off;
        end
    end
endfunction

function automatic void train(input logic ex_v, input logic ex_t, input logic [31:0] ex_pc,
                              input logic [31:0] ex_tgt, input logic [31:0] ex_inst,
                              input logic push_v, input logic [31:0] push_d,
                              input logic ex_stall, input logic id_stall);
    int c;
    int b;
    c = counter_slot(ex_pc);
    b = btb_slot(ex_pc);
    if (ex_v) begin
        if (ex_t && ctr_mirror[c] != bpu_cfg_pkg::ctr_max) begin
            ctr_mirror[c] = ctr_mirror[c] + 2'b01;
        end else if (!ex_t && ctr_mirror[c] != 2'b00) begin
            ctr_mirror[c] = ctr_mirror[c] - 2'b01;
        end
        if (ex_t) begin
            btb_valid_mirror[b]  = 1'b1;
            btb_pc_mirror[b]     = ex_pc;
            btb_target_mirror[b] = ex_tgt;
        end
    end
    // pop first, then the push lands in the freed slot
    if (ex_v && ex_t && is_return(ex_inst) && !ex_stall && ras_count > 0) begin
        ras_count--;
    end
    if (push_v && !ex_stall && !id_stall && ras_count < bpu_cfg_pkg::ras_depth) begin
        ras_mirror[ras_count] = push_d;
        ras_count++;
    end
endfunction

`endif

// ==== dv/tb_bpu_top.sv ====
`timescale 1ns/1ns

module tb_bpu_top;

    localparam int random_cycles   = 1840;
    localparam int directed_cycles = 160;  // bound on reset and directed phases
    localparam int timeout_cycles  = (random_cycles + directed_cycles) * 5 / 4;
    localparam logic [31:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] ret_pc   = 32'h0000_4000;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc_i;
    logic [31:0] if_inst_i;
    logic        ex_branch_valid_i;
    logic        ex_branch_taken_i;
    logic [31:0] ex_pc_i;
    logic [31:0] ex_target_i;
    logic [31:0] ex_inst_i;
    logic        id_ras_push_valid_i;
    logic [31:0] id_ras_push_data_i;
    logic        ex_stall_valid_i;
    logic        id_stall_i;
    logic        branch_or_not_o;
    logic        pdt_res_o;
    logic [31:0] pdt_pc_o;
    string       test_name;
    int          cycle_cnt;

    `include "bpu_ref_model.svh"

    bpu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else fail_run($sformatf("Mismatch in %s: %s expected %h actual %h",
                                test_name, sig, exp, act));
    endtask

    function automatic logic [31:0] branch_inst(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], rv_isa_pkg::op_branch};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
    endfunction

    function automatic logic [31:0] jalr_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_isa_pkg::op_jalr};
    endfunction

    function automatic logic [31:0] ret_inst();
        return jalr_inst(5'd0, rv_isa_pkg::reg_ra, 12'd0);
    endfunction

    // random word with any opcode outside the three control transfers
    function automatic logic [31:0] non_control_inst();
        logic [31:0] inst;
        inst = $urandom;
        if (inst[6:0] == rv_isa_pkg::op_branch || inst[6:0] == rv_isa_pkg::op_jal
            || inst[6:0] == rv_isa_pkg::op_jalr) begin
            inst[6:0] = rv_isa_pkg::op_other;
        end
        return inst;
    endfunction

    function automatic logic [31:0] random_inst();
        case ($urandom % 5)
            0: return branch_inst(13'($urandom) & 13'h1ffe);
            1: return jal_inst(5'd1, 21'($urandom) & 21'h1f_fffe);
            2: return jalr_inst(5'd0, ($urandom % 2) == 0 ? rv_isa_pkg::reg_ra
                                                          : rv_isa_pkg::reg_t0, 12'd0);
            3: return jalr_inst(5'($urandom % 2), 5'd1, 12'($urandom % 2));  // sometimes a ret
            default: return non_control_inst();
        endcase
    endfunction

    // 4 tags x 16 btb slots so entries collide
    function automatic logic [31:0] pick_pc();
        return 32'h0000_1000 + 32'h40 * ($urandom % 4) + 32'd4 * ($urandom % 16);
    endfunction

    task automatic set_inputs(input logic [31:0] pc, input logic [31:0] inst,
                              input logic ex_v, input logic ex_t,
                              input logic [31:0] e_pc, input logic [31:0] e_tgt,
                              input logic [31:0] e_inst, input logic push_v,
                              input logic [31:0] push_d, input logic ex_st, input logic id_st);
        if_pc_i             = pc;
        if_inst_i           = inst;
        ex_branch_valid_i   = ex_v;
        ex_branch_taken_i   = ex_t;
        ex_pc_i             = e_pc;
        ex_target_i         = e_tgt;
        ex_inst_i           = e_inst;
        id_ras_push_valid_i = push_v;
        id_ras_push_data_i  = push_d;
        ex_stall_valid_i    = ex_st;
        id_stall_i          = id_st;
    endtask

    task automatic fetch(input logic [31:0] pc, input logic [31:0] inst);
        @(negedge clk);
        set_inputs(pc, inst, 1'b0, 1'b0, 32'd0, 32'd0, nop_inst, 1'b0, 32'd0, 1'b0, 1'b0);
    endtask

    task automatic execute(input logic [31:0] pc, input logic [31:0] inst,
                           input logic [31:0] e_pc, input logic [31:0] e_inst,
                           input logic taken, input logic [31:0] target);
        @(negedge clk);
        set_inputs(pc, inst, 1'b1, taken, e_pc, target, e_inst, 1'b0, 32'd0, 1'b0, 1'b0);
    endtask

    // a return is fetched every cycle, so pushes and pops show up at once
    task automatic ras_op(input logic push_v, input logic [31:0] push_d, input logic pop,
                          input logic ex_st, input logic id_st);
        @(negedge clk);
        set_inputs(ret_pc, ret_inst(), pop, pop, ret_pc, 32'd0, ret_inst(), push_v, push_d,
                   ex_st, id_st);
    endtask

    // compare 2 ns before the rising edge, then let the model take the edge too
    initial begin
        logic        exp_br;
        logic        exp_taken;
        logic [31:0] exp_pc;
        forever begin
            @(negedge clk);
            #8;
            if (!rst) begin
                predict(if_pc_i, if_inst_i, id_ras_push_valid_i, id_ras_push_data_i,
                        exp_br, exp_taken, exp_pc);
                check_value("branch_or_not_o", 32'(exp_br), 32'(branch_or_not_o));
                check_value("pdt_res_o", 32'(exp_taken), 32'(pdt_res_o));
                check_value("pdt_pc_o", exp_pc, pdt_pc_o);
            end
            @(posedge clk);
            if (!rst) begin
                train(ex_branch_valid_i, ex_branch_taken_i, ex_pc_i, ex_target_i, ex_inst_i,
                      id_ras_push_valid_i, id_ras_push_data_i, ex_stall_valid_i, id_stall_i);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= timeout_cycles) begin
                fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                   timeout_cycles));
            end
        end
    end

    initial begin
        logic [31:0] pc;
        void'($urandom(32'h9427_b4fb));
        test_name = "reset";
        reset_model();
        rst = 1'b1;
        set_inputs(32'd0, nop_inst, 1'b0, 1'b0, 32'd0, 32'd0, nop_inst, 1'b0, 32'd0, 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        rst = 1'b0;

        test_name = "reset_state";
        for (int i = 0; i < 4; i++) begin
            pc = pick_pc();
            fetch(pc, branch_inst(13'h1fe0));
            fetch(pc, jal_inst(5'd1, (i % 2 == 0) ? 21'h0_0100 : 21'h1f_ff00));
            fetch(pc, non_control_inst());
            fetch(pc, jalr_inst(5'd1, 5'd6, 12'h010));
            fetch(pc, ret_inst());  // empty stack
        end

        test_name = "bimodal";
        for (int i = 0; i < 4; i++) begin
            pc = 32'h0000_2000 + 32'(4 * i);
            repeat (3) execute(pc, branch_inst(13'h0020), pc, branch_inst(13'h0020), 1'b1,
                               pc + 32'h20);
            execute(pc, branch_inst(13'h0020), pc, branch_inst(13'h0020), 1'b0, 32'd0);
            fetch(pc, branch_inst(13'h0020));  // still taken after one miss
            repeat (4) execute(pc, branch_inst(13'h0020), pc, branch_inst(13'h0020), 1'b0,
                               32'd0);
            fetch(pc, branch_inst(13'h0020));
        end

        test_name = "btb";
        for (int i = 0; i < 4; i++) begin
            pc = 32'h0000_3000 + 32'(4 * i);
            repeat (2) execute(pc, branch_inst(13'h0100), pc, branch_inst(13'h0100), 1'b1,
                               32'h0000_9000 + 32'(16 * i));
            fetch(pc, branch_inst(13'h0100));
            fetch(pc, jal_inst(5'd1, 21'h0_0200));
            fetch(pc + 32'h80, jal_inst(5'd1, 21'h0_0200));  // same slot, other tag
            fetch(pc + 32'h80, branch_inst(13'h0100));
        end

        test_name = "return_stack";
        for (int i = 0; i < 3; i++) begin
            ras_op(1'b1, 32'h0000_5000 + 32'(4 * i), 1'b0, 1'b0, 1'b0);
        end
        repeat (4) ras_op(1'b0, 32'd0, 1'b1, 1'b0, 1'b0);  // last pop finds it empty
        ras_op(1'b1, 32'h0000_6000, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            ras_op(1'b1, 32'h0000_7000 + 32'(4 * i), 1'b0, 1'b0, 1'b0);  // overflow
        end
        repeat (9) ras_op(1'b0, 32'd0, 1'b1, 1'b0, 1'b0);

        test_name = "stall";
        ras_op(1'b1, 32'h0000_a000, 1'b0, 1'b0, 1'b0);
        ras_op(1'b1, 32'h0000_a004, 1'b0, 1'b0, 1'b0);
        ras_op(1'b1, 32'h0000_a008, 1'b0, 1'b0, 1'b1);
        ras_op(1'b1, 32'h0000_a00c, 1'b0, 1'b1, 1'b0);
        ras_op(1'b0, 32'd0, 1'b1, 1'b1, 1'b0);
        ras_op(1'b0, 32'd0, 1'b1, 1'b0, 1'b1);  // decode stall does not hold the pop
        ras_op(1'b1, 32'h0000_a010, 1'b1, 1'b0, 1'b0);
        repeat (3) ras_op(1'b0, 32'd0, 1'b1, 1'b0, 1'b0);

        test_name = "random_mix";
        repeat (random_cycles) begin
            @(negedge clk);
            set_inputs(pick_pc(), random_inst(), ($urandom % 2) == 0, ($urandom % 2) == 0,
                       pick_pc(), $urandom & 32'hffff_fffc,
                       ($urandom % 2) == 0 ? ret_inst() : random_inst(),
                       ($urandom % 6) == 0, $urandom & 32'hffff_fffc,
                       ($urandom % 8) == 0, ($urandom % 8) == 0);
        end

        repeat (2) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== bpu_top.f ====
+incdir+dv
src/rv_isa_pkg.sv
src/bpu_cfg_pkg.sv
src/inst_classifier.sv
src/bimodal_table.sv
src/branch_target_buffer.sv
src/return_stack.sv
src/next_pc_select.sv
src/bpu_top.sv
dv/tb_bpu_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_bpu_top
FILELIST   := bpu_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
